// ==== sources.f ====
common/axi_pkg.sv
common/video_pkg.sv
mm2s/mm2s_ctrl.sv
mm2s/burst_reader.sv
mm2s/line_fifo.sv
verilog/pixel_scaler.sv
mm2s/mm2s_top.sv
sim/mm2s_checker.sv
sim/tb_mm2s.sv

// ==== Bender.yml ====
package:
  name: mm2s

sources:
  - common/axi_pkg.sv
  - common/video_pkg.sv
  - mm2s/mm2s_ctrl.sv
  - mm2s/burst_reader.sv
  - mm2s/line_fifo.sv
  - verilog/pixel_scaler.sv
  - mm2s/mm2s_top.sv
  - target: simulation
    files:
      - sim/mm2s_checker.sv
      - sim/tb_mm2s.sv

// ==== sim/tb_mm2s.sv ====
`timescale 1ns/1ps

module tb_mm2s
	import video_pkg::*;
	import axi_pkg::*;
();
	localparam int n_rows = 5;
	localparam int n_cols = 9;
	localparam int sync_limit = 200;
	localparam int frame_limit = 40000;

	// Each row holds frame_addr, stride, win_left, win_width, win_top, win_height,
	// dst_width, dst_height and the random handshake flag
	int cfg_tbl [n_rows*n_cols] = '{
		'h1000, 64, 0, 64, 0, 8, 64, 8, 0,
		'h2000, 48, 7, 22, 2, 5, 22, 5, 0,
		'h3100, 64, 5, 37, 1, 13, 15, 6, 1,
		'h5004, 80, 2, 50, 4, 10, 33, 7, 1,
		'h4000, 32, 10, 9, 3, 4, 1, 1, 0
	};

	logic clk;
	logic resetn;
	logic fsync;
	logic [addr_width-1:0] frame_addr;
	logic [stride_bits-1:0] stride;
	logic [img_wbits-1:0] win_left;
	logic [img_wbits-1:0] win_width;
	logic [img_hbits-1:0] win_top;
	logic [img_hbits-1:0] win_height;
	logic [img_wbits-1:0] dst_width;
	logic [img_hbits-1:0] dst_height;
	logic sof;
	logic [addr_width-1:0] araddr;
	logic [7:0] arlen;
	logic arvalid;
	logic arready = 1'b0;
	logic [data_width-1:0] rdata = '0;
	logic rlast = 1'b0;
	logic rvalid = 1'b0;
	logic rready;
	logic [pixel_width-1:0] tdata;
	logic tuser;
	logic tlast;
	logic tvalid;
	logic tready = 1'b0;
	logic random_mode;
	logic [15:0] lfsr = 16'd5476;
	logic [addr_width-1:0] burst_addr;
	logic [7:0] beats_left;
	int err_cnt;
	int pix_cnt;
	int frame_cnt;
	int sof_cnt;
	int tuser_cnt;

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [7:0] mem_byte(input logic [addr_width-1:0] a);
		return 8'(a * 7 + a / 256);
	endfunction

	// Lane k of the little-endian word holds byte a+k
	function automatic logic [data_width-1:0] word_at(input logic [addr_width-1:0] a);
		logic [data_width-1:0] w;
		for (int k = 0; k < beat_bytes; k++)
			w[k*8 +: 8] = mem_byte(a + addr_width'(k));
		return w;
	endfunction

	mm2s_top mm2s_top_i (
		.clk(clk),
		.resetn(resetn),
		.stride(stride),
		.win_left(win_left),
		.win_width(win_width),
		.win_top(win_top),
		.win_height(win_height),
		.dst_width(dst_width),
		.dst_height(dst_height),
		.frame_addr(frame_addr),
		.fsync(fsync),
		.sof(sof),
		.araddr(araddr),
		.arlen(arlen),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rlast(rlast),
		.rvalid(rvalid),
		.rready(rready),
		.tdata(tdata),
		.tuser(tuser),
		.tlast(tlast),
		.tvalid(tvalid),
		.tready(tready)
	);

	mm2s_checker monitor_i (
		.clk(clk),
		.resetn(resetn),
		.frame_addr(frame_addr),
		.stride(stride),
		.win_left(win_left),
		.win_width(win_width),
		.win_top(win_top),
		.win_height(win_height),
		.dst_width(dst_width),
		.dst_height(dst_height),
		.sof(sof),
		.araddr(araddr),
		.arlen(arlen),
		.arvalid(arvalid),
		.arready(arready),
		.tdata(tdata),
		.tuser(tuser),
		.tlast(tlast),
		.tvalid(tvalid),
		.tready(tready),
		.err_cnt(err_cnt),
		.pix_cnt(pix_cnt),
		.frame_cnt(frame_cnt),
		.sof_cnt(sof_cnt),
		.tuser_cnt(tuser_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Memory slave serving one burst at a time
	always @(posedge clk) begin
		if (!resetn) begin
			arready <= 1'b0;
			tready <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
			rdata <= '0;
			burst_addr <= '0;
			beats_left <= '0;
		end else begin
			if (random_mode) begin
				lfsr = lfsr_step(lfsr);
				tready <= lfsr[0];
				lfsr = lfsr_step(lfsr);
				arready <= lfsr[0];
			end else begin
				tready <= 1'b1;
				arready <= 1'b1;
			end
			if (arvalid && arready) begin
				burst_addr <= araddr;
				beats_left <= arlen;
				rdata <= word_at(araddr);
				rlast <= arlen == 8'd0;
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				if (rlast) begin
					rvalid <= 1'b0;
					rlast <= 1'b0;
				end else begin
					burst_addr <= burst_addr + addr_width'(beat_bytes);
					rdata <= word_at(burst_addr + addr_width'(beat_bytes));
					rlast <= beats_left == 8'd1;
					beats_left <= beats_left - 8'd1;
				end
			end
		end
	end

	initial begin
		int base;
		int waited;
		int pix_total;
		int tb_errs;
		int timeouts;
		resetn = 1'b0;
		fsync = 1'b0;
		frame_addr = '0;
		stride = '0;
		win_left = '0;
		win_width = '0;
		win_top = '0;
		win_height = '0;
		dst_width = '0;
		dst_height = '0;
		random_mode = 1'b0;
		pix_total = 0;
		tb_errs = 0;
		timeouts = 0;
		repeat (16) @(posedge clk);
		resetn <= 1'b1;

		for (int n = 0; n < n_rows; n++) begin
			base = n * n_cols;
			@(posedge clk);
			frame_addr <= addr_width'(cfg_tbl[base]);
			stride <= stride_bits'(cfg_tbl[base+1]);
			win_left <= img_wbits'(cfg_tbl[base+2]);
			win_width <= img_wbits'(cfg_tbl[base+3]);
			win_top <= img_hbits'(cfg_tbl[base+4]);
			win_height <= img_hbits'(cfg_tbl[base+5]);
			dst_width <= img_wbits'(cfg_tbl[base+6]);
			dst_height <= img_hbits'(cfg_tbl[base+7]);
			random_mode <= cfg_tbl[base+8] != 0;
			fsync <= 1'b1;
			pix_total += cfg_tbl[base+6] * cfg_tbl[base+7];

			// Hold fsync until the controller takes it
			waited = 0;
			@(posedge clk);
			while (!sof && waited < sync_limit) begin
				@(posedge clk);
				waited++;
			end
			fsync <= 1'b0;
			if (!sof) begin
				$display("Timeout: frame %0d was never started", n);
				timeouts++;
				break;
			end

			// A second fsync inside the frame must be ignored
			@(posedge clk);
			fsync <= 1'b1;
			@(posedge clk);
			fsync <= 1'b0;

			waited = 0;
			while (frame_cnt != n + 1 && waited < frame_limit) begin
				@(posedge clk);
				waited++;
			end
			if (frame_cnt != n + 1) begin
				$display("Timeout: frame %0d did not finish streaming", n);
				timeouts++;
				break;
			end
		end

		if (sof_cnt != n_rows || tuser_cnt != n_rows || frame_cnt != n_rows) begin
			$display("Frame counts are wrong: %0d sof, %0d tuser, %0d frames for %0d fsyncs",
				sof_cnt, tuser_cnt, frame_cnt, n_rows);
			tb_errs++;
		end
		if (pix_cnt != pix_total) begin
			$display("Pixel count is wrong: %0d streamed, %0d expected", pix_cnt, pix_total);
			tb_errs++;
		end

		$display("Errors %0d, timeouts %0d, pixels %0d, frames %0d",
			err_cnt + tb_errs, timeouts, pix_cnt, frame_cnt);
		if (err_cnt == 0 && tb_errs == 0 && timeouts == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== sim/mm2s_checker.sv ====
`timescale 1ns/1ps

module mm2s_checker
	import video_pkg::*;
	import axi_pkg::*;
(
	input  logic                   clk,
	input  logic                   resetn,
	input  logic [addr_width-1:0]  frame_addr,
	input  logic [stride_bits-1:0] stride,
	input  logic [img_wbits-1:0]   win_left,
	input  logic [img_wbits-1:0]   win_width,
	input  logic [img_hbits-1:0]   win_top,
	input  logic [img_hbits-1:0]   win_height,
	input  logic [img_wbits-1:0]   dst_width,
	input  logic [img_hbits-1:0]   dst_height,
	input  logic                   sof,
	input  logic [addr_width-1:0]  araddr,
	input  logic [7:0]             arlen,
	input  logic                   arvalid,
	input  logic                   arready,
	input  logic [pixel_width-1:0] tdata,
	input  logic                   tuser,
	input  logic                   tlast,
	input  logic                   tvalid,
	input  logic                   tready,
	output int                     err_cnt,
	output int                     pix_cnt,
	output int                     frame_cnt,
	output int                     sof_cnt,
	output int                     tuser_cnt
);
	int n_err;
	int n_pix;
	int n_frame;
	int n_sof;
	int n_tuser;
	int row;
	int col;
	logic running;
	logic held;
	logic [pixel_width-1:0] held_data;
	logic [pixel_width-1:0] exp_pix;
	logic exp_user;
	logic exp_last;

	function automatic int ceil_div(input int num, input int den);
		return (num + den - 1) / den;
	endfunction

	function automatic logic [7:0] mem_byte(input logic [addr_width-1:0] a);
		return 8'(a * 7 + a / 256);
	endfunction

	// Nearest-neighbour source pixel for destination row r, column c
	function automatic logic [pixel_width-1:0] expected_pixel(input int r, input int c);
		int src_row;
		int src_col;
		logic [addr_width-1:0] a;
		src_row = int'(win_top) + ceil_div(r * int'(win_height), int'(dst_height));
		src_col = int'(win_left) + ceil_div(c * int'(win_width), int'(dst_width));
		a = frame_addr + addr_width'(src_row * int'(stride) + src_col);
		return mem_byte(a);
	endfunction

	always @(posedge clk) begin
		if (!resetn) begin
			n_err = 0;
			n_pix = 0;
			n_frame = 0;
			n_sof = 0;
			n_tuser = 0;
			row = 0;
			col = 0;
			running = 1'b0;
			held = 1'b0;
		end else begin
			// Bursts are whole words and never longer than burst_len
			if (arvalid && arready) begin
				if (int'(arlen) >= burst_len) begin
					$display("Error arlen: expected at most %h, got %h",
						8'(burst_len - 1), arlen);
					n_err++;
				end
				if (araddr % beat_bytes != 0) begin
					$display("Burst address %h is not word aligned", araddr);
					n_err++;
				end
			end
			if (held && (!tvalid || tdata !== held_data)) begin
				$display("Stream beat changed before it was accepted at row %0d col %0d", row, col);
				n_err++;
			end
			if (sof) begin
				n_sof++;
				if (running) begin
					$display("sof pulsed while frame %0d was still streaming", n_frame);
					n_err++;
				end
				running = 1'b1;
				row = 0;
				col = 0;
			end
			if (tvalid && tready) begin
				if (tuser)
					n_tuser++;
				if (!running) begin
					$display("Stream beat arrived outside of any frame");
					n_err++;
				end else begin
					exp_pix = expected_pixel(row, col);
					exp_user = row == 0 && col == 0;
					exp_last = col == int'(dst_width) - 1;
					if (tdata !== exp_pix) begin
						$display("Error tdata: expected %h, got %h at row %0d col %0d",
							exp_pix, tdata, row, col);
						n_err++;
					end
					if (tuser !== exp_user) begin
						$display("Error tuser: expected %h, got %h at row %0d col %0d",
							exp_user, tuser, row, col);
						n_err++;
					end
					if (tlast !== exp_last) begin
						$display("Error tlast: expected %h, got %h at row %0d col %0d",
							exp_last, tlast, row, col);
						n_err++;
					end
					n_pix++;
					if (exp_last) begin
						col = 0;
						row++;
						if (row == int'(dst_height)) begin
							running = 1'b0;
							n_frame++;
						end
					end else begin
						col++;
					end
				end
			end
			held = tvalid && !tready;
			held_data = tdata;
		end
		err_cnt <= n_err;
		pix_cnt <= n_pix;
		frame_cnt <= n_frame;
		sof_cnt <= n_sof;
		tuser_cnt <= n_tuser;
	end

endmodule

// ==== mm2s/mm2s_top.sv ====
`timescale 1ns/1ps

module mm2s_top
	import video_pkg::*;
	import axi_pkg::*;
(
	input  logic                   clk,
	input  logic                   resetn,
	input  logic [stride_bits-1:0] stride,
	input  logic [img_wbits-1:0]   win_left,
	input  logic [img_wbits-1:0]   win_width,
	input  logic [img_hbits-1:0]   win_top,
	input  logic [img_hbits-1:0]   win_height,
	input  logic [img_wbits-1:0]   dst_width,
	input  logic [img_hbits-1:0]   dst_height,
	input  logic [addr_width-1:0]  frame_addr,
	input  logic                   fsync,
	output logic                   sof,
	output logic [addr_width-1:0]  araddr,
	output logic [7:0]             arlen,
	output logic                   arvalid,
	input  logic                   arready,
	input  logic [data_width-1:0]  rdata,
	input  logic                   rlast,
	input  logic                   rvalid,
	output logic                   rready,
	output logic [pixel_width-1:0] tdata,
	output logic                   tuser,
	output logic                   tlast,
	output logic                   tvalid,
	input  logic                   tready
);
	logic line_req;
	logic [addr_width-1:0] line_addr;
	logic [img_wbits-1:0] line_words;
	logic reader_idle;
	logic frame_start;
	logic line_done;
	logic wr_en;
	logic [data_width-1:0] wr_data;
	logic rd_en;
	logic [data_width-1:0] rd_data;
	logic fifo_full;
	logic fifo_empty;

	mm2s_ctrl mm2s_ctrl_i (
		.clk(clk),
		.resetn(resetn),
		.fsync(fsync),
		.frame_addr(frame_addr),
		.stride(stride),
		.win_left(win_left),
		.win_width(win_width),
		.win_top(win_top),
		.win_height(win_height),
		.dst_height(dst_height),
		.reader_idle(reader_idle),
		.line_done(line_done),
		.sof(sof),
		.frame_start(frame_start),
		.line_req(line_req),
		.line_addr(line_addr),
		.line_words(line_words)
	);

	burst_reader burst_reader_i (
		.clk(clk),
		.resetn(resetn),
		.line_req(line_req),
		.line_addr(line_addr),
		.line_words(line_words),
		.arready(arready),
		.rdata(rdata),
		.rlast(rlast),
		.rvalid(rvalid),
		.fifo_full(fifo_full),
		.araddr(araddr),
		.arlen(arlen),
		.arvalid(arvalid),
		.rready(rready),
		.reader_idle(reader_idle),
		.wr_en(wr_en),
		.wr_data(wr_data)
	);

	line_fifo line_fifo_i (
		.clk(clk),
		.resetn(resetn),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.rd_en(rd_en),
		.rd_data(rd_data),
		.full(fifo_full),
		.empty(fifo_empty)
	);

	pixel_scaler pixel_scaler_i (
		.clk(clk),
		.resetn(resetn),
		.frame_start(frame_start),
		.win_left(win_left),
		.win_width(win_width),
		.dst_width(dst_width),
		.rd_data(rd_data),
		.empty(fifo_empty),
		.tready(tready),
		.rd_en(rd_en),
		.tdata(tdata),
		.tuser(tuser),
		.tlast(tlast),
		.tvalid(tvalid),
		.line_done(line_done)
	);

endmodule

// ==== verilog/pixel_scaler.sv ====
`timescale 1ns/1ps

module pixel_scaler
	import video_pkg::*;
	import axi_pkg::*;
(
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   frame_start,
	input  logic [img_wbits-1:0]   win_left,
	input  logic [img_wbits-1:0]   win_width,
	input  logic [img_wbits-1:0]   dst_width,
	input  logic [data_width-1:0]  rd_data,
	input  logic                   empty,
	input  logic                   tready,
	output logic                   rd_en,
	output logic [pixel_width-1:0] tdata,
	output logic                   tuser,
	output logic                   tlast,
	output logic                   tvalid,
	output logic                   line_done
);
	localparam int acc_bits = img_wbits + 2;

	logic [pix_sel_bits-1:0] pix_idx;
	logic [pix_sel_bits-1:0] cur_idx;
	logic [pix_sel_bits-1:0] sel;
	logic [pix_sel_bits:0] consumed;
	logic [img_wbits-1:0] src_cnt;
	logic [img_wbits-1:0] src_next;
	logic [img_wbits-1:0] dst_cnt;
	logic [img_wbits-1:0] left;
	logic signed [acc_bits-1:0] hacc;
	logic signed [acc_bits-1:0] acc_walk;
	logic signed [acc_bits-1:0] acc_sel;
	logic signed [acc_bits-1:0] w_step;
	logic signed [acc_bits-1:0] d_step;
	logic found;
	logic step;
	logic line_end;
	logic word_end;
	logic at_start;
	logic first;

	assign w_step = {2'b00, win_width};
	assign d_step = {2'b00, dst_width};
	// First word of a line starts at the window's byte lane
	assign cur_idx = at_start ? win_left[pix_sel_bits-1:0] : pix_idx;
	assign left = win_width - src_cnt;
	assign step = !empty && (!tvalid || tready);

	// Search the rest of this word for the next selected pixel
	always_comb begin
		found = 1'b0;
		sel = cur_idx;
		acc_sel = hacc;
		acc_walk = hacc;
		consumed = '0;
		for (int k = 0; k < pix_per_word; k++) begin
			if (!found && k >= int'(cur_idx) && img_wbits'(consumed) < left) begin
				consumed = consumed + 1'b1;
				if (acc_walk >= 0) begin
					found = 1'b1;
					sel = pix_sel_bits'(k);
					acc_sel = acc_walk;
				end else begin
					acc_walk = acc_walk + d_step;
				end
			end
		end
	end

	assign src_next = src_cnt + img_wbits'(consumed);
	assign line_end = src_next == win_width;
	assign word_end = line_end || !found || sel == pix_sel_bits'(pix_per_word - 1);
	assign rd_en = step && word_end;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			tvalid <= 1'b0;
			tuser <= 1'b0;
			tlast <= 1'b0;
			line_done <= 1'b0;
			first <= 1'b0;
			at_start <= 1'b1;
			pix_idx <= '0;
			src_cnt <= '0;
			dst_cnt <= '0;
			hacc <= '0;
		end else begin
			line_done <= tvalid && tready && tlast;
			if (tvalid && tready)
				tvalid <= 1'b0;
			if (step) begin
				if (found) begin
					tvalid <= 1'b1;
					tdata <= rd_data[sel*pixel_width +: pixel_width];
					tuser <= first;
					tlast <= dst_cnt == dst_width - 1;
					first <= 1'b0;
				end
				at_start <= line_end;
				if (line_end) begin
					src_cnt <= '0;
					dst_cnt <= '0;
					hacc <= '0;
				end else begin
					pix_idx <= word_end ? '0 : sel + 1'b1;
					src_cnt <= src_next;
					dst_cnt <= dst_cnt + img_wbits'(found);
					hacc <= found ? acc_sel - w_step + d_step : acc_walk;
				end
			end
			if (frame_start)
				first <= 1'b1;
		end
	end

endmodule

// ==== mm2s/line_fifo.sv ====
`timescale 1ns/1ps

module line_fifo
	import axi_pkg::*;
#(
	parameter int depth = 16
) (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  wr_en,
	input  logic [data_width-1:0] wr_data,
	input  logic                  rd_en,
	output logic [data_width-1:0] rd_data,
	output logic                  full,
	output logic                  empty
);
	localparam int ptr_bits = $clog2(depth);

	logic [data_width-1:0] mem [depth];
	logic [ptr_bits:0] wr_ptr;
	logic [ptr_bits:0] rd_ptr;

	// Extra pointer bit tells full from empty
	assign empty = wr_ptr == rd_ptr;
	assign full = (wr_ptr[ptr_bits] != rd_ptr[ptr_bits])
		&& (wr_ptr[ptr_bits-1:0] == rd_ptr[ptr_bits-1:0]);

	// Head word is always visible
	assign rd_data = mem[rd_ptr[ptr_bits-1:0]];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr[ptr_bits-1:0]] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!resetn) !(wr_en && full));
	a_no_underflow: assert property (@(posedge clk) disable iff (!resetn) !(rd_en && empty));

endmodule

// ==== mm2s/burst_reader.sv ====
`timescale 1ns/1ps

module burst_reader
	import video_pkg::*;
	import axi_pkg::*;
(
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  line_req,
	input  logic [addr_width-1:0] line_addr,
	input  logic [img_wbits-1:0]  line_words,
	input  logic                  arready,
	input  logic [data_width-1:0] rdata,
	input  logic                  rlast,
	input  logic                  rvalid,
	input  logic                  fifo_full,
	output logic [addr_width-1:0] araddr,
	output logic [7:0]            arlen,
	output logic                  arvalid,
	output logic                  rready,
	output logic                  reader_idle,
	output logic                  wr_en,
	output logic [data_width-1:0] wr_data
);
	logic [img_wbits-1:0] remaining;
	logic [img_wbits-1:0] burst_words;
	logic [addr_width-1:0] next_addr;
	logic [7:0] beat_cnt;

	function automatic logic [7:0] len_of(input logic [img_wbits-1:0] words);
		if (words > img_wbits'(burst_len))
			return 8'(burst_len - 1);
		return 8'(words - 1);
	endfunction

	assign burst_words = img_wbits'({1'b0, arlen} + 9'd1);

	// Stall R when the line buffer has no room
	assign rready = !fifo_full;
	assign wr_en = rvalid && rready;
	assign wr_data = rdata;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			arvalid <= 1'b0;
			reader_idle <= 1'b1;
			remaining <= '0;
			beat_cnt <= '0;
		end else begin
			if (line_req) begin
				arvalid <= 1'b1;
				araddr <= line_addr;
				arlen <= len_of(line_words);
				remaining <= line_words;
				reader_idle <= 1'b0;
			end else if (arvalid && arready) begin
				arvalid <= 1'b0;
				remaining <= remaining - burst_words;
				next_addr <= araddr + burst_words * beat_bytes;
			end else if (wr_en && rlast) begin
				if (remaining == '0) begin
					reader_idle <= 1'b1;
				end else begin
					arvalid <= 1'b1;
					araddr <= next_addr;
					arlen <= len_of(remaining);
				end
			end

			if (arvalid && arready)
				beat_cnt <= '0;
			else if (wr_en)
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	a_rlast_len: assert property (@(posedge clk) disable iff (!resetn)
		wr_en |-> (rlast == (beat_cnt == arlen)));

endmodule

// ==== mm2s/mm2s_ctrl.sv ====
`timescale 1ns/1ps

module mm2s_ctrl
	import video_pkg::*;
	import axi_pkg::*;
(
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   fsync,
	input  logic [addr_width-1:0]  frame_addr,
	input  logic [stride_bits-1:0] stride,
	input  logic [img_wbits-1:0]   win_left,
	input  logic [img_wbits-1:0]   win_width,
	input  logic [img_hbits-1:0]   win_top,
	input  logic [img_hbits-1:0]   win_height,
	input  logic [img_hbits-1:0]   dst_height,
	input  logic                   reader_idle,
	input  logic                   line_done,
	output logic                   sof,
	output logic                   frame_start,
	output logic                   line_req,
	output logic [addr_width-1:0]  line_addr,
	output logic [img_wbits-1:0]   line_words
);
	localparam int acc_bits = img_hbits + 2;

	typedef enum logic [1:0] {st_idle, st_seek, st_request, st_drain} state_t;

	state_t state;
	logic [addr_width-1:0] row_addr;
	logic signed [acc_bits-1:0] vacc;
	logic signed [acc_bits-1:0] h_step;
	logic signed [acc_bits-1:0] d_step;
	logic [img_hbits-1:0] req_cnt;
	logic [img_hbits-1:0] done_cnt;
	logic [img_hbits-1:0] done_next;
	logic [img_wbits:0] words_raw;

	assign h_step = {2'b00, win_height};
	assign d_step = {2'b00, dst_height};
	assign done_next = done_cnt + img_hbits'(line_done);

	// Lead-in pixels plus window, rounded up to whole words
	assign words_raw = {1'b0, win_width} + (img_wbits+1)'(win_left[pix_sel_bits-1:0])
		+ (img_wbits+1)'(pix_per_word - 1);

	assign frame_start = sof;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= st_idle;
			sof <= 1'b0;
			line_req <= 1'b0;
			req_cnt <= '0;
			done_cnt <= '0;
			vacc <= '0;
		end else begin
			sof <= 1'b0;
			line_req <= 1'b0;
			if (line_done)
				done_cnt <= done_next;
			case (state)
			st_idle: begin
				if (fsync) begin
					sof <= 1'b1;
					row_addr <= frame_addr + win_top * stride + win_left;
					vacc <= '0;
					req_cnt <= '0;
					done_cnt <= '0;
					state <= st_seek;
				end
			end
			// Step over source rows that no destination row maps to
			st_seek: begin
				if (vacc >= 0) begin
					state <= st_request;
				end else begin
					vacc <= vacc + d_step;
					row_addr <= row_addr + stride;
				end
			end
			st_request: begin
				if (reader_idle) begin
					line_req <= 1'b1;
					line_addr <= row_addr & ~addr_width'(beat_bytes - 1);
					line_words <= img_wbits'(words_raw >> pix_sel_bits);
					vacc <= vacc - h_step + d_step;
					row_addr <= row_addr + stride;
					req_cnt <= req_cnt + 1'b1;
					state <= (req_cnt == dst_height - 1) ? st_drain : st_seek;
				end
			end
			st_drain: begin
				if (done_next == dst_height)
					state <= st_idle;
			end
			default: state <= st_idle;
			endcase
		end
	end

	// Reader takes one line at a time
	a_req_idle: assert property (@(posedge clk) disable iff (!resetn)
		line_req |-> reader_idle);

endmodule

// ==== common/video_pkg.sv ====
package video_pkg;

	// Bits in one pixel
	localparam int pixel_width = 8;

	// Coordinate and size widths
	localparam int img_wbits = 12;
	localparam int img_hbits = 12;

	// Line stride in bytes
	localparam int stride_bits = 14;

	// Pixels packed into one memory word
	localparam int pix_per_word = axi_pkg::data_width / pixel_width;
	localparam int pix_sel_bits = 2;

endpackage

// ==== common/axi_pkg.sv ====
package axi_pkg;

	localparam int addr_width = 32;
	localparam int data_width = 32;

	// Longest burst in words
	localparam int burst_len = 4;

	localparam int beat_bytes = data_width / 8;

endpackage
